/* tests/bp_vectors.txt */
# id op res_valid res_pc res_target res_cf res_taken res_counter pres_valid pres_pc
# pc_cur pc_prev stall flush skip exp_valid exp_sel (f = not checked), all hex
1 0 0 0 0 0 0 0 0 0 00000100 00000000 0 0 0 0 2
1 0 0 0 0 0 0 0 0 0 00000104 00000100 0 0 0 0 2
2 0 1 00000200 00001000 2 1 0 0 0 00000108 00000104 0 0 0 0 2
2 0 0 0 0 0 0 0 0 0 00000200 00000108 0 0 0 0 2
2 0 0 0 0 0 0 0 0 0 00002200 00000200 0 0 0 1 1
2 0 0 0 0 0 0 0 0 0 00000300 00002200 0 0 0 0 2
3 0 1 00000300 00000400 1 1 1 0 0 00000304 00000300 0 0 0 0 2
3 0 0 0 0 0 0 0 0 0 00000300 00000304 0 0 0 0 2
3 0 1 00000300 00000400 1 1 2 0 0 00000300 00000300 0 0 0 1 1
3 0 1 00000300 00000400 1 0 0 0 0 00000300 00000300 0 0 0 1 1
3 0 0 0 0 0 0 0 0 0 00000300 00000300 0 0 0 1 1
3 0 0 0 0 0 0 0 0 0 00000500 00000300 0 0 0 1 1
4 0 1 00000810 00002000 2 1 0 0 0 00000500 00000500 0 0 0 0 2
4 0 1 00000814 00003000 3 1 0 0 0 00000500 00000500 0 0 0 0 2
4 0 0 0 0 0 0 0 0 0 00000810 00000500 0 0 0 0 2
4 0 0 0 0 0 0 0 0 0 00000810 00000810 0 0 0 1 1
4 0 1 0000081c 00004000 2 1 0 0 0 00000818 00000814 0 0 0 1 2
4 0 0 0 0 0 0 0 0 0 00000818 00000818 0 0 0 0 2
4 0 0 0 0 0 0 0 0 0 00000200 00000818 0 0 0 1 2
5 0 0 0 0 0 0 0 0 0 00000200 00000200 0 0 0 1 1
5 0 0 0 0 0 0 0 0 0 00000500 00000200 1 0 0 1 1
5 0 0 0 0 0 0 0 0 0 00000600 00000500 1 0 0 1 1
5 0 0 0 0 0 0 0 0 0 00000200 00000600 0 0 0 1 1
5 0 0 0 0 0 0 0 0 0 00000200 00000200 0 1 0 1 1
5 0 0 0 0 0 0 0 0 0 00000200 00000200 0 0 0 0 2
5 0 0 0 0 0 0 0 0 0 00000200 00000200 0 0 1 0 1
5 0 0 0 0 0 0 0 0 0 00000200 00000200 0 0 0 1 1
6 0 0 0 0 0 0 0 1 00000200 00000200 00000200 0 0 0 1 1
6 0 0 0 0 0 0 0 0 0 00000200 00000200 0 0 0 1 1
6 0 1 00000810 00005000 2 1 0 1 00000810 00000200 00000200 0 0 0 0 2
6 0 0 0 0 0 0 0 0 0 00000810 00000200 0 0 0 0 2
6 0 0 0 0 0 0 0 0 0 00000300 00000810 0 0 0 1 1
7 1 0 0 0 0 0 0 0 0 00000000 00000300 0 0 0 1 1
7 1 0 0 0 0 0 0 0 0 00000000 00000000 0 0 0 f f
7 1 0 0 0 0 0 0 0 0 00000000 00000000 0 0 0 f f

/* build.f */
src/bp_pkg.sv
src/bp_update_if.sv
src/bht.sv
src/btb.sv
src/branch_predictor.sv
src/bp_top.sv
tests/bp_sva.sv
tests/bp_checker.sv
tests/tb_bp.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_bp
FILELIST  = build.f

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* tests/tb_bp.sv */
`timescale 1ns/1ps

module tb_bp;

	logic             clk;
	logic             rst;
	logic             stall;
	logic             flush;
	logic             skip;
	bp_pkg::virt_t    pc_cur;
	bp_pkg::virt_t    pc_prev;
	logic             res_valid;
	bp_pkg::virt_t    res_pc;
	bp_pkg::virt_t    res_target;
	bp_pkg::cf_t      res_cf;
	logic             res_taken;
	bp_pkg::counter_t res_counter;
	logic             pres_valid;
	bp_pkg::virt_t    pres_pc;
	logic             pred_valid;
	logic             pred_taken;
	logic             pred_wait_delayslot;
	bp_pkg::cf_t      pred_cf;
	bp_pkg::counter_t pred_counter;
	bp_pkg::virt_t    pred_target;
	logic [1:0]       prediction_sel;
	int               test_id;
	logic [3:0]       exp_valid;
	logic [3:0]       exp_sel;
	logic             done;
	int               errors;
	logic             reported;
	int               seed;

	bp_top i_dut (.*);

	bp_checker checker_inst (.*);

	bind branch_predictor bp_sva sva_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		int            fd;
		int            n;
		int            w;
		string         line;
		logic [31:0]   f [17];
		logic          timed_out;
		logic          bad_vector;
		{stall, flush, skip, res_valid, res_taken, pres_valid, done} = '0;
		{pc_cur, pc_prev, res_pc, res_target, pres_pc} = '0;
		res_cf = bp_pkg::cf_none;
		res_counter = '0;
		test_id = 0;
		exp_valid = 4'hf;
		exp_sel = 4'hf;
		seed = 32'h62ed_c76c;
		timed_out = 1'b0;
		bad_vector = 1'b0;
		rst = 1'b1;
		fd = $fopen("tests/bp_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/bp_vectors.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			repeat (8) @(posedge clk);
			for (n = 0; n < 200 && !$feof(fd); n++) begin
				if ($fgets(line, fd) == 0 || line.len() < 2 || line[0] == "#")
					continue;
				if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]) != 17) begin
					$display("malformed vector line: %s", line);
					bad_vector = 1'b1;
					continue;
				end
				@(negedge clk);
				rst = 1'b0;
				test_id = int'(f[0]);
				res_valid = f[2][0];
				res_pc = f[3];
				res_target = f[4];
				res_cf = bp_pkg::cf_t'(f[5][1:0]);
				res_taken = f[6][0];
				res_counter = f[7][1:0];
				pres_valid = f[8][0];
				pres_pc = f[9];
				// op 1 is a filler lookup at a random aligned pc
				pc_cur = (f[1] == 32'd1) ? ($random(seed) & 32'hffff_fffc) : f[10];
				pc_prev = f[11];
				stall = f[12][0];
				flush = f[13][0];
				skip = f[14][0];
				exp_valid = f[15][3:0];
				exp_sel = f[16][3:0];
			end
			if (n >= 200) begin
				$display("vector file did not end within 200 lines");
				timed_out = 1'b1;
			end
			$fclose(fd);
			@(negedge clk);
			{res_valid, pres_valid, stall, flush, skip} = '0;
			done = 1'b1;
			for (w = 0; w < 20 && !reported; w++)
				@(posedge clk);
			if (!reported) begin
				$display("checker gave no final report within 20 cycles");
				timed_out = 1'b1;
			end
			if (errors == 0 && !timed_out && !bad_vector)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

/* tests/bp_checker.sv */
`timescale 1ns/1ps

module bp_checker (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  logic             flush,
	input  logic             skip,
	input  bp_pkg::virt_t    pc_cur,
	input  bp_pkg::virt_t    pc_prev,
	input  logic             res_valid,
	input  bp_pkg::virt_t    res_pc,
	input  bp_pkg::virt_t    res_target,
	input  bp_pkg::cf_t      res_cf,
	input  logic             res_taken,
	input  bp_pkg::counter_t res_counter,
	input  logic             pres_valid,
	input  bp_pkg::virt_t    pres_pc,
	input  logic             pred_valid,
	input  logic             pred_taken,
	input  logic             pred_wait_delayslot,
	input  bp_pkg::cf_t      pred_cf,
	input  bp_pkg::counter_t pred_counter,
	input  bp_pkg::virt_t    pred_target,
	input  logic [1:0]       prediction_sel,
	input  int               test_id,
	input  logic [3:0]       exp_valid,
	input  logic [3:0]       exp_sel,
	input  logic             done,
	output int               errors,
	output logic             reported
);

	// model tables, 64 entries per bank, tag is pc[25:9]
	logic             ent_v [2][64];
	logic [16:0]      ent_tag [2][64];
	bp_pkg::virt_t    ent_tgt [2][64];
	bp_pkg::cf_t      ent_cf [2][64];
	bp_pkg::counter_t cnt [2][64];

	// registered reads and stall hold copies
	bp_pkg::cf_t      rd_cf [2];
	bp_pkg::virt_t    rd_tgt [2];
	bp_pkg::counter_t rd_cnt [2];
	bp_pkg::cf_t      hd_cf [2];
	bp_pkg::virt_t    hd_tgt [2];
	bp_pkg::counter_t hd_cnt [2];
	logic             was_stall;
	logic             was_flush;
	int               cur_test;
	int               test_errs;
	int               checks;
	int               tests;

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errs++;
			$display("Fail %0t: test %0d %s is %h, expected %h", $time, cur_test, what, got, exp);
		end
	endtask

	task automatic close_test();
		tests++;
		$display("test %0d %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "bad", test_errs);
	endtask

	always @(posedge clk) begin : step
		logic             s;
		logic             held;
		bp_pkg::cf_t      c;
		bp_pkg::counter_t n;
		bp_pkg::virt_t    t;
		if (rst) begin
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < 64; i++) begin
					ent_v[b][i] = 1'b0;
					ent_tag[b][i] = '0;
					ent_tgt[b][i] = '0;
					ent_cf[b][i] = bp_pkg::cf_none;
					cnt[b][i] = 2'b01;
				end
				rd_cf[b] = bp_pkg::cf_none;
				rd_tgt[b] = '0;
				rd_cnt[b] = 2'b01;
				hd_cf[b] = bp_pkg::cf_none;
				hd_tgt[b] = '0;
				hd_cnt[b] = '0;
			end
			was_stall = 1'b0;
			was_flush = 1'b0;
			errors = 0;
			reported = 1'b0;
			cur_test = 0;
			test_errs = 0;
			checks = 0;
			tests = 0;
		end else if (done) begin
			if (!reported) begin
				if (cur_test != 0)
					close_test();
				$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
				reported = 1'b1;
			end
		end else begin
			if (test_id != cur_test) begin
				if (cur_test != 0)
					close_test();
				cur_test = test_id;
				test_errs = 0;
			end
			held = was_stall | was_flush;
			if (pc_prev[2])
				s = 1'b1;
			else
				s = ((held ? hd_cf[0] : rd_cf[0]) == bp_pkg::cf_none);
			c = held ? hd_cf[s] : rd_cf[s];
			t = held ? hd_tgt[s] : rd_tgt[s];
			n = held ? hd_cnt[s] : rd_cnt[s];
			compare("valid", 32'(pred_valid),
				32'(!skip && !was_flush && c != bp_pkg::cf_none));
			compare("cf", 32'(pred_cf), 32'(c));
			compare("target", pred_target, t);
			compare("counter", 32'(pred_counter), 32'(n));
			compare("taken", 32'(pred_taken), 32'((c == bp_pkg::cf_branch) ? n[1] : 1'b1));
			compare("wait_delayslot", 32'(pred_wait_delayslot),
				32'(s && pc_prev[4:3] == 2'b11));
			compare("prediction_sel", 32'(prediction_sel), 32'({s, ~s}));
			if (exp_valid != 4'hf)
				compare("valid from vectors", 32'(pred_valid), 32'(exp_valid[0]));
			if (exp_sel != 4'hf)
				compare("sel from vectors", 32'(prediction_sel), 32'(exp_sel[1:0]));

			// state update in the order the hardware sees it at this edge
			for (int b = 0; b < 2; b++) begin
				if (flush) begin
					hd_cf[b] = bp_pkg::cf_none;
					hd_tgt[b] = '0;
					hd_cnt[b] = '0;
				end else if (!was_stall) begin
					hd_cf[b] = rd_cf[b];
					hd_tgt[b] = rd_tgt[b];
					hd_cnt[b] = rd_cnt[b];
				end
				rd_tgt[b] = ent_tgt[b][pc_cur[8:3]];
				rd_cnt[b] = cnt[b][pc_cur[8:3]];
				if (ent_v[b][pc_cur[8:3]] && ent_tag[b][pc_cur[8:3]] == pc_cur[25:9])
					rd_cf[b] = ent_cf[b][pc_cur[8:3]];
				else
					rd_cf[b] = bp_pkg::cf_none;
			end
			was_stall = stall;
			was_flush = flush;
			if (pres_valid)
				ent_v[pres_pc[2]][pres_pc[8:3]] = 1'b0;
			if (res_valid) begin
				ent_v[res_pc[2]][res_pc[8:3]] = 1'b1;
				ent_tag[res_pc[2]][res_pc[8:3]] = res_pc[25:9];
				ent_tgt[res_pc[2]][res_pc[8:3]] = res_target;
				ent_cf[res_pc[2]][res_pc[8:3]] = res_cf;
			end
			if (res_valid && res_cf == bp_pkg::cf_branch) begin
				if (res_taken)
					n = (res_counter == 2'b11) ? res_counter : res_counter + 2'd1;
				else
					n = (res_counter == 2'b00) ? res_counter : res_counter - 2'd1;
				cnt[res_pc[2]][res_pc[8:3]] = n;
			end
		end
	end

endmodule

/* tests/bp_sva.sv */
`timescale 1ns/1ps

module bp_sva (
	input logic                clk,
	input logic                rst,
	input logic                flush,
	input logic                skip,
	input bp_pkg::prediction_t prediction,
	input logic [1:0]          prediction_sel
);

	a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot(prediction_sel))
		else $error("prediction_sel is not one-hot");

	// flushed fetch never predicts in the following cycle
	a_flush_drop: assert property (@(posedge clk) disable iff (rst)
		flush |=> !prediction.valid)
		else $error("prediction valid in the cycle after flush");

	a_skip_drop: assert property (@(posedge clk) disable iff (rst)
		skip |-> !prediction.valid)
		else $error("prediction valid while skip is high");

	a_jump_taken: assert property (@(posedge clk) disable iff (rst)
		(prediction.valid && prediction.cf != bp_pkg::cf_branch) |-> prediction.taken)
		else $error("jump predicted not taken");

endmodule

/* src/bp_top.sv */
`timescale 1ns/1ps

module bp_top #(
	parameter int table_size = 64,
	parameter int line_width = 256
)(
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  logic             flush,
	input  logic             skip,
	input  bp_pkg::virt_t    pc_cur,
	input  bp_pkg::virt_t    pc_prev,
	input  logic             res_valid,
	input  bp_pkg::virt_t    res_pc,
	input  bp_pkg::virt_t    res_target,
	input  bp_pkg::cf_t      res_cf,
	input  logic             res_taken,
	input  bp_pkg::counter_t res_counter,
	input  logic             pres_valid,
	input  bp_pkg::virt_t    pres_pc,
	output logic             pred_valid,
	output logic             pred_taken,
	output logic             pred_wait_delayslot,
	output bp_pkg::cf_t      pred_cf,
	output bp_pkg::counter_t pred_counter,
	output bp_pkg::virt_t    pred_target,
	output logic [1:0]       prediction_sel
);

	bp_pkg::presolved_t  presolved;
	bp_pkg::prediction_t prediction;

	assign presolved = '{valid: pres_valid, pc: pres_pc};

	assign pred_valid          = prediction.valid;
	assign pred_taken          = prediction.taken;
	assign pred_wait_delayslot = prediction.wait_delayslot;
	assign pred_cf             = prediction.cf;
	assign pred_counter        = prediction.counter;
	assign pred_target         = prediction.target;

	branch_predictor #(
		.table_size ( table_size ),
		.line_width ( line_width )
	) bp_inst (
		.clk,
		.rst,
		.stall,
		.flush,
		.skip,
		.pc_cur,
		.pc_prev,
		.res_valid,
		.res_taken,
		.res_pc,
		.res_target,
		.res_cf,
		.res_counter,
		.presolved,
		.prediction,
		.prediction_sel
	);

endmodule

/* src/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor #(
	parameter int table_size = bp_pkg::default_table_size,
	parameter int line_width = bp_pkg::default_line_width
)(
	input  logic                clk,
	input  logic                rst,
	input  logic                stall,
	input  logic                flush,
	input  logic                skip,
	// 4-byte aligned fetch addresses, pc_prev is last cycle's pc_cur
	input  bp_pkg::virt_t       pc_cur,
	input  bp_pkg::virt_t       pc_prev,
	// resolved branch from execute
	input  logic                res_valid,
	input  logic                res_taken,
	input  bp_pkg::virt_t       res_pc,
	input  bp_pkg::virt_t       res_target,
	input  bp_pkg::cf_t         res_cf,
	input  bp_pkg::counter_t    res_counter,
	input  bp_pkg::presolved_t  presolved,
	output bp_pkg::prediction_t prediction,
	output logic [1:0]          prediction_sel
);

	localparam int line_offset = $clog2(line_width / 8);

	bp_update_if btb_upd ();
	bp_update_if bht_upd ();

	bp_pkg::counter_t     [1:0] bht_rd, bht_hold, bht_src;
	bp_pkg::btb_predict_t [1:0] btb_rd, btb_hold, btb_src;

	logic                 pipe_stall;
	logic                 pipe_flush;
	logic                 sel;
	bp_pkg::btb_predict_t btb_sel;
	bp_pkg::counter_t     bht_sel;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			btb_hold <= '0;
			bht_hold <= '0;
		end else if (!pipe_stall) begin
			btb_hold <= btb_rd;
			bht_hold <= bht_rd;
		end

		if (rst) begin
			pipe_stall <= 1'b0;
			pipe_flush <= 1'b0;
		end else begin
			pipe_stall <= stall;
			pipe_flush <= flush;
		end
	end

	// a stalled fetch keeps looking at what it saw before the stall
	assign btb_src = (pipe_stall | pipe_flush) ? btb_hold : btb_rd;
	assign bht_src = (pipe_stall | pipe_flush) ? bht_hold : bht_rd;

	// odd word address only has slot 1 left in the pair
	assign sel = pc_prev[2] ? 1'b1 : (btb_src[0].cf == bp_pkg::cf_none);

	assign btb_sel = btb_src[sel];
	assign bht_sel = bht_src[sel];
	assign prediction_sel = {sel, ~sel};

	always_comb begin
		prediction.valid   = ~skip & ~pipe_flush & (btb_sel.cf != bp_pkg::cf_none);
		prediction.cf      = btb_sel.cf;
		prediction.target  = btb_sel.target;
		prediction.counter = bht_sel;
		if (btb_sel.cf == bp_pkg::cf_branch)
			prediction.taken = bht_sel[1];
		else
			prediction.taken = 1'b1;
		// last pair of the line, so the delay slot comes with the next line
		prediction.wait_delayslot = sel & (&pc_prev[line_offset-1:3]);
	end

	assign btb_upd.valid   = res_valid;
	assign btb_upd.pc      = res_pc;
	assign btb_upd.target  = res_target;
	assign btb_upd.cf      = res_cf;
	assign btb_upd.taken   = res_taken;
	assign btb_upd.counter = res_counter;

	// only conditional branches train the counters
	assign bht_upd.valid   = res_valid & (res_cf == bp_pkg::cf_branch);
	assign bht_upd.pc      = res_pc;
	assign bht_upd.target  = res_target;
	assign bht_upd.cf      = res_cf;
	assign bht_upd.taken   = res_taken;
	assign bht_upd.counter = res_counter;

	bht #(
		.table_size ( table_size )
	) bht_inst (
		.clk,
		.rst,
		.vaddr   ( pc_cur  ),
		.upd     ( bht_upd ),
		.predict ( bht_rd  )
	);

	btb #(
		.table_size ( table_size )
	) btb_inst (
		.clk,
		.rst,
		.vaddr     ( pc_cur    ),
		.upd       ( btb_upd   ),
		.presolved ( presolved ),
		.predict   ( btb_rd    )
	);

endmodule

/* src/btb.sv */
`timescale 1ns/1ps

module btb #(
	parameter int table_size = bp_pkg::default_table_size
)(
	input  logic                       clk,
	input  logic                       rst,
	input  bp_pkg::virt_t              vaddr,
	bp_update_if.tbl                   upd,
	input  bp_pkg::presolved_t         presolved,
	output bp_pkg::btb_predict_t [1:0] predict
);

	localparam int index_bits = $clog2(table_size);
	localparam int tag_lsb = 3 + index_bits;

	bp_pkg::btb_entry_t mem [2][table_size];

	// registered read of both banks plus the tag it must match
	bp_pkg::btb_entry_t [1:0] rd_entry;
	bp_pkg::btb_tag_t         rd_tag;

	function automatic logic [index_bits-1:0] index_of(input bp_pkg::virt_t a);
		return a[3 +: index_bits];
	endfunction

	// pc bits above the stored tag width alias onto the same entry
	function automatic bp_pkg::btb_tag_t tag_of(input bp_pkg::virt_t a);
		return bp_pkg::btb_tag_t'(a >> tag_lsb);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < 2; b++)
				for (int i = 0; i < table_size; i++)
					mem[b][i] <= '0;
			rd_entry <= '0;
			rd_tag   <= '0;
		end else begin
			if (presolved.valid)
				mem[presolved.pc[2]][index_of(presolved.pc)].valid <= 1'b0;
			// issued after the invalidation so a same-address install wins
			if (upd.valid) begin
				mem[upd.pc[2]][index_of(upd.pc)] <= '{
					valid:  1'b1,
					tag:    tag_of(upd.pc),
					target: upd.target,
					cf:     upd.cf
				};
			end
			rd_entry[0] <= mem[0][index_of(vaddr)];
			rd_entry[1] <= mem[1][index_of(vaddr)];
			rd_tag      <= tag_of(vaddr);
		end
	end

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			predict[s].target = rd_entry[s].target;
			if (rd_entry[s].valid && rd_entry[s].tag == rd_tag)
				predict[s].cf = rd_entry[s].cf;
			else
				predict[s].cf = bp_pkg::cf_none;
		end
	end

endmodule

/* src/bht.sv */
`timescale 1ns/1ps

module bht #(
	parameter int table_size = bp_pkg::default_table_size
)(
	input  logic                   clk,
	input  logic                   rst,
	input  bp_pkg::virt_t          vaddr,
	bp_update_if.tbl               upd,
	output bp_pkg::counter_t [1:0] predict
);

	localparam int index_bits = $clog2(table_size);

	// one bank per slot of the 8-byte pair
	bp_pkg::counter_t mem [2][table_size];

	logic [index_bits-1:0] rd_idx;
	logic [index_bits-1:0] wr_idx;
	bp_pkg::counter_t      next_counter;

	function automatic bp_pkg::counter_t step(input bp_pkg::counter_t c, input logic taken);
		if (taken)
			return (c == 2'b11) ? c : c + 2'd1;
		else
			return (c == 2'b00) ? c : c - 2'd1;
	endfunction

	assign rd_idx = vaddr[3 +: index_bits];
	assign wr_idx = upd.pc[3 +: index_bits];

	// train from the counter that execute saw, not from the table
	assign next_counter = step(upd.counter, upd.taken);

	always_ff @(posedge clk) begin
		if (rst) begin
			// weakly not taken
			for (int b = 0; b < 2; b++)
				for (int i = 0; i < table_size; i++)
					mem[b][i] <= 2'b01;
			predict <= {2'b01, 2'b01};
		end else begin
			if (upd.valid)
				mem[upd.pc[2]][wr_idx] <= next_counter;
			predict[0] <= mem[0][rd_idx];
			predict[1] <= mem[1][rd_idx];
		end
	end

endmodule

/* src/bp_update_if.sv */
`timescale 1ns/1ps

interface bp_update_if;

	logic             valid;
	bp_pkg::virt_t    pc;
	bp_pkg::virt_t    target;
	bp_pkg::cf_t      cf;
	logic             taken;
	bp_pkg::counter_t counter;

	// produced by the predictor from resolved branches
	modport source (
		output valid, pc, target, cf, taken, counter
	);

	// consumed by the prediction tables, always accepted
	modport tbl (
		input valid, pc, target, cf, taken, counter
	);

endinterface

/* src/bp_pkg.sv */
package bp_pkg;

	// table geometry used when no size is given
	localparam int default_table_size = 4096;
	localparam int default_line_width = 256;

	// tag bits above the 8-byte pair and the bank index
	localparam int btb_tag_width = 32 - 3 - $clog2(default_table_size);

	typedef logic [31:0] virt_t;

	typedef enum logic [1:0] {
		cf_none     = 2'd0,
		cf_branch   = 2'd1,
		cf_jump     = 2'd2,
		cf_jump_reg = 2'd3
	} cf_t;

	// upper bit set means predict taken
	typedef logic [1:0] counter_t;

	typedef logic [btb_tag_width-1:0] btb_tag_t;

	typedef struct packed {
		logic     valid;
		btb_tag_t tag;
		virt_t    target;
		cf_t      cf;
	} btb_entry_t;

	typedef struct packed {
		cf_t   cf;
		virt_t target;
	} btb_predict_t;

	// decode found no control flow in this slot
	typedef struct packed {
		logic  valid;
		virt_t pc;
	} presolved_t;

	typedef struct packed {
		logic     valid;
		logic     taken;
		logic     wait_delayslot;
		cf_t      cf;
		counter_t counter;
		virt_t    target;
	} prediction_t;

endpackage
